//--- common/rv_exec_pkg.sv
package rv_exec_pkg;

    typedef enum logic [6:0] {
        op_r_type = 7'b0110011,
        op_i_type = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_fence  = 7'b0001111,
        op_system = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_nop
    } alu_op_t;

    typedef enum logic [2:0] {
        ph_idle,
        ph_fetch,
        ph_decode,
        ph_execute,
        ph_writeback
    } phase_t;

    // same word, register view and immediate view
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
    } instr_u;

    // alu and shift functions, register and immediate forms
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

endpackage

//--- alu/alu.sv
`timescale 1ns/1ns

module alu (
    input  logic [31:0]          alu_operand1,
    input  logic [31:0]          alu_operand2,
    input  rv_exec_pkg::alu_op_t alu_op,
    output logic [31:0]          alu_result
);
    import rv_exec_pkg::*;

    logic [4:0] shamt;

    assign shamt = alu_operand2[4:0];

    always_comb begin
        case (alu_op)
            alu_add:  alu_result = alu_operand1 + alu_operand2;
            alu_sub:  alu_result = alu_operand1 - alu_operand2;
            alu_and:  alu_result = alu_operand1 & alu_operand2;
            alu_or:   alu_result = alu_operand1 | alu_operand2;
            alu_xor:  alu_result = alu_operand1 ^ alu_operand2;
            alu_sll:  alu_result = alu_operand1 << shamt;
            alu_srl:  alu_result = alu_operand1 >> shamt;
            alu_sra:  alu_result = $signed(alu_operand1) >>> shamt; // sign fill
            alu_slt:  alu_result = {31'b0, $signed(alu_operand1) < $signed(alu_operand2)};
            alu_sltu: alu_result = {31'b0, alu_operand1 < alu_operand2};
            default:  alu_result = '0; // nop
        endcase
    end
endmodule

//--- alu/alu_controller.sv
`timescale 1ns/1ns

module alu_controller (
    input  logic                 clk,
    input  logic                 arst_n,
    input  rv_exec_pkg::phase_t  next_phase,
    input  rv_exec_pkg::opcode_t opcode,
    input  logic [2:0]           funct3,
    input  logic                 funct7_5,
    input  logic [31:0]          rs1_val,
    input  logic [31:0]          rs2_val,
    input  logic [31:0]          imm,
    input  logic [31:0]          now_pc,
    output logic [31:0]          alu_operand1,
    output logic [31:0]          alu_operand2,
    output rv_exec_pkg::alu_op_t alu_op
);
    import rv_exec_pkg::*;

    logic [31:0] sel_operand1;
    logic [31:0] sel_operand2;
    alu_op_t     sel_op;

    // registered one phase early, so select on the phase being entered
    always_comb begin
        sel_operand1 = '0;
        sel_operand2 = '0;
        sel_op       = alu_nop;
        case (next_phase)
            ph_decode: begin
                case (opcode)
                    op_jal, op_branch: begin // pc relative target
                        sel_operand1 = now_pc;
                        sel_operand2 = imm;
                        sel_op       = alu_add;
                    end
                    op_jalr: begin
                        sel_operand1 = rs1_val;
                        sel_operand2 = imm;
                        sel_op       = alu_add;
                    end
                    default: ;
                endcase
            end
            ph_execute: begin
                case (opcode)
                    op_r_type, op_i_type: begin
                        sel_operand1 = rs1_val;
                        sel_operand2 = (opcode == op_r_type) ? rs2_val : imm;
                        case (funct3)
                            f3_add_sub: sel_op = (opcode == op_r_type && funct7_5) ?
                                                 alu_sub : alu_add; // no subi
                            f3_sll:     sel_op = alu_sll;
                            f3_slt:     sel_op = alu_slt;
                            f3_sltu:    sel_op = alu_sltu;
                            f3_xor:     sel_op = alu_xor;
                            f3_srl_sra: sel_op = funct7_5 ? alu_sra : alu_srl;
                            f3_or:      sel_op = alu_or;
                            f3_and:     sel_op = alu_and;
                        endcase
                    end
                    op_branch: begin
                        case (funct3)
                            f3_beq, f3_bne:   sel_op = alu_sub;  // zero test
                            f3_blt, f3_bge:   sel_op = alu_slt;
                            f3_bltu, f3_bgeu: sel_op = alu_sltu;
                            default:          sel_op = alu_nop;
                        endcase
                        if (sel_op != alu_nop) begin
                            sel_operand1 = rs1_val;
                            sel_operand2 = rs2_val;
                        end
                    end
                    op_load, op_store, op_jalr: begin
                        sel_operand1 = rs1_val;
                        sel_operand2 = imm;
                        sel_op       = alu_add;
                    end
                    op_lui: begin
                        sel_operand2 = imm; // 0 + imm
                        sel_op       = alu_add;
                    end
                    op_auipc, op_jal: begin
                        sel_operand1 = now_pc;
                        sel_operand2 = imm;
                        sel_op       = alu_add;
                    end
                    default: ; // fence, system
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_operand1 <= '0;
            alu_operand2 <= '0;
            alu_op       <= alu_nop;
        end else begin
            alu_operand1 <= sel_operand1;
            alu_operand2 <= sel_operand2;
            alu_op       <= sel_op;
        end
    end
endmodule

//--- hdl/phase_sequencer.sv
`timescale 1ns/1ns

module phase_sequencer (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                start,
    output rv_exec_pkg::phase_t phase,
    output rv_exec_pkg::phase_t next_phase,
    output logic                busy,
    output logic                done
);
    import rv_exec_pkg::*;

    always_comb begin
        case (phase)
            ph_idle:      next_phase = start ? ph_fetch : ph_idle; // start dropped elsewhere
            ph_fetch:     next_phase = ph_decode;
            ph_decode:    next_phase = ph_execute;
            ph_execute:   next_phase = ph_writeback;
            ph_writeback: next_phase = ph_idle;
            default:      next_phase = ph_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= ph_idle;
        end else begin
            phase <= next_phase;
        end
    end

    assign busy = (phase != ph_idle);
    assign done = (phase == ph_writeback); // single cycle, writeback lasts one
endmodule

//--- hdl/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 start,
    input  logic [31:0]          instr,
    input  logic [31:0]          pc,
    input  logic [31:0]          rs1_data,
    input  logic [31:0]          rs2_data,
    input  rv_exec_pkg::phase_t  phase,
    output rv_exec_pkg::opcode_t opcode,
    output logic [2:0]           funct3,
    output logic                 funct7_5,
    output logic [4:0]           rd_addr,
    output logic [31:0]          imm,
    output logic [31:0]          now_pc,
    output logic [31:0]          rs1_val,
    output logic [31:0]          rs2_val,
    output logic                 illegal
);
    import rv_exec_pkg::*;

    instr_u      ir;
    logic        accept;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign accept = start && (phase == ph_idle);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir <= 32'h0000_0013; // addi x0, x0, 0
        end else if (accept) begin
            ir <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            now_pc  <= pc;
            rs1_val <= rs1_data;
            rs2_val <= rs2_data;
        end
    end

    assign opcode   = opcode_t'(ir.r_fmt.opcode);
    assign funct3   = ir.r_fmt.funct3;
    assign funct7_5 = ir.r_fmt.funct7[5]; // sub and sra select
    assign rd_addr  = ir.r_fmt.rd;

    assign imm_i = {{20{ir.i_fmt.imm12[11]}}, ir.i_fmt.imm12};
    assign imm_s = {{20{ir[31]}}, ir.r_fmt.funct7, ir.r_fmt.rd};
    assign imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {ir[31:12], 12'b0};
    assign imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

    always_comb begin
        case (opcode)
            op_store:         imm = imm_s;
            op_branch:        imm = imm_b;
            op_lui, op_auipc: imm = imm_u;
            op_jal:           imm = imm_j;
            default:          imm = imm_i; // alu imm, load, jalr
        endcase
    end

    always_comb begin
        case (opcode)
            op_r_type: illegal = !(ir.r_fmt.funct7 == 7'b0000000 ||
                                   (ir.r_fmt.funct7 == 7'b0100000 &&
                                    (funct3 == f3_add_sub || funct3 == f3_srl_sra)));
            op_i_type: begin
                case (funct3)
                    f3_sll:     illegal = (ir.r_fmt.funct7 != 7'b0000000);
                    f3_srl_sra: illegal = (ir.r_fmt.funct7 != 7'b0000000) &&
                                          (ir.r_fmt.funct7 != 7'b0100000);
                    default:    illegal = 1'b0;
                endcase
            end
            op_load:   illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            op_store:  illegal = funct3[2] || (funct3 == 3'b011);
            op_branch: illegal = (funct3[2:1] == 2'b01);
            op_jalr:   illegal = (funct3 != 3'b000);
            op_lui, op_auipc, op_jal, op_fence, op_system: illegal = 1'b0;
            default:   illegal = 1'b1; // unknown opcode
        endcase
    end
endmodule

//--- hdl/result_unit.sv
`timescale 1ns/1ns

module result_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    input  rv_exec_pkg::phase_t  phase,
    input  rv_exec_pkg::opcode_t opcode,
    input  logic [2:0]           funct3,
    input  logic [31:0]          now_pc,
    input  logic [31:0]          alu_result,
    output logic                 rd_we,
    output logic [31:0]          rd_data,
    output logic [31:0]          next_pc,
    output logic [31:0]          mem_addr,
    output logic                 mem_read,
    output logic                 mem_write
);
    import rv_exec_pkg::*;

    logic [31:0] target;
    logic [31:0] pc_plus4;
    logic        taken;
    logic        link;

    assign pc_plus4 = now_pc + 32'd4;
    assign link     = (opcode == op_jal) || (opcode == op_jalr);

    // sub result for eq and ne, compare bit for the rest
    always_comb begin
        case (funct3)
            f3_beq:  taken = (alu_result == 32'd0);
            f3_bne:  taken = (alu_result != 32'd0);
            f3_blt:  taken = alu_result[0];
            f3_bge:  taken = !alu_result[0];
            f3_bltu: taken = alu_result[0];
            f3_bgeu: taken = !alu_result[0];
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_we     <= 1'b0;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
        end else if (phase == ph_execute) begin
            rd_we     <= (opcode inside {op_r_type, op_i_type, op_lui, op_auipc,
                                         op_jal, op_jalr});
            mem_read  <= (opcode == op_load);
            mem_write <= (opcode == op_store);
        end
    end

    always_ff @(posedge clk) begin
        if (phase == ph_decode) begin
            target <= alu_result; // jump or branch target
        end
        if (phase == ph_execute) begin
            rd_data  <= link ? pc_plus4 : alu_result;
            mem_addr <= alu_result;
            case (opcode)
                op_jal:    next_pc <= target;
                op_jalr:   next_pc <= {target[31:1], 1'b0};
                op_branch: next_pc <= taken ? target : pc_plus4;
                default:   next_pc <= pc_plus4;
            endcase
        end
    end
endmodule

//--- hdl/rv_exec_top.sv
`timescale 1ns/1ns

module rv_exec_top (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        start,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    output logic        busy,
    output logic        done,
    output logic [4:0]  rd_addr,
    output logic        rd_we,
    output logic [31:0] rd_data,
    output logic [31:0] next_pc,
    output logic [31:0] mem_addr,
    output logic        mem_read,
    output logic        mem_write,
    output logic        illegal
);
    import rv_exec_pkg::*;

    phase_t      phase;
    phase_t      next_phase;
    opcode_t     opcode;
    logic [2:0]  funct3;
    logic        funct7_5;
    logic [31:0] imm;
    logic [31:0] now_pc;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] alu_operand1;
    logic [31:0] alu_operand2;
    alu_op_t     alu_op;
    logic [31:0] alu_result;
    logic        ru_rd_we;
    logic [31:0] ru_next_pc;
    logic        ru_mem_read;
    logic        ru_mem_write;

    phase_sequencer u_phase_sequencer (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .phase      (phase),
        .next_phase (next_phase),
        .busy       (busy),
        .done       (done)
    );

    instr_decoder u_instr_decoder (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .instr    (instr),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .phase    (phase),
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7_5 (funct7_5),
        .rd_addr  (rd_addr),
        .imm      (imm),
        .now_pc   (now_pc),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .illegal  (illegal)
    );

    alu_controller u_alu_controller (
        .clk          (clk),
        .arst_n       (arst_n),
        .next_phase   (next_phase),
        .opcode       (opcode),
        .funct3       (funct3),
        .funct7_5     (funct7_5),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .imm          (imm),
        .now_pc       (now_pc),
        .alu_operand1 (alu_operand1),
        .alu_operand2 (alu_operand2),
        .alu_op       (alu_op)
    );

    alu u_alu (
        .alu_operand1 (alu_operand1),
        .alu_operand2 (alu_operand2),
        .alu_op       (alu_op),
        .alu_result   (alu_result)
    );

    result_unit u_result_unit (
        .clk        (clk),
        .arst_n     (arst_n),
        .phase      (phase),
        .opcode     (opcode),
        .funct3     (funct3),
        .now_pc     (now_pc),
        .alu_result (alu_result),
        .rd_we      (ru_rd_we),
        .rd_data    (rd_data),
        .next_pc    (ru_next_pc),
        .mem_addr   (mem_addr),
        .mem_read   (ru_mem_read),
        .mem_write  (ru_mem_write)
    );

    // illegal instruction retires with no side effects
    assign rd_we     = ru_rd_we && !illegal;
    assign mem_read  = ru_mem_read && !illegal;
    assign mem_write = ru_mem_write && !illegal;
    assign next_pc   = illegal ? now_pc + 32'd4 : ru_next_pc;
endmodule

//--- verif/rv_exec_top_asserts.sv
`timescale 1ns/1ns

module rv_exec_top_asserts (
    input logic clk,
    input logic arst_n,
    input logic start,
    input logic busy,
    input logic done,
    input logic illegal,
    input logic rd_we,
    input logic mem_read,
    input logic mem_write
);

    done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done)
        else $error("done held high for more than one cycle");

    // start taken in idle, writeback three edges after the sampling edge
    start_to_done: assert property (@(posedge clk) disable iff (!arst_n)
        start && !busy |=> ##3 done)
        else $error("done did not follow an accepted start by three cycles");

    illegal_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        illegal |-> !rd_we && !mem_read && !mem_write)
        else $error("register write or memory strobe while illegal is set");

    idle_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !busy)
        else $error("busy high right after reset release");

endmodule

bind rv_exec_top rv_exec_top_asserts u_rv_exec_top_asserts (.*);

//--- verif/tb_rv_exec_top.sv
`timescale 1ns/1ns

module tb_rv_exec_top;

    typedef struct {
        string       name;
        logic [31:0] word;
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] rd_data;
        logic [31:0] next_pc;
        logic [31:0] mem_addr;
        logic [3:0]  flags; // rd_we, mem_read, mem_write, illegal
    } row_t;

    logic        clk;
    logic        arst_n;
    logic        start;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        busy;
    logic        done;
    logic [4:0]  rd_addr;
    logic        rd_we;
    logic [31:0] rd_data;
    logic [31:0] next_pc;
    logic [31:0] mem_addr;
    logic        mem_read;
    logic        mem_write;
    logic        illegal;

    row_t   rows[$];
    integer seed;
    int     busy_poke_row;
    int     cycle_count;
    int     cycle_limit;
    int     check_count;
    int     error_count;

    rv_exec_top u_rv_exec_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // encoders with rd x5, rs1 x1, rs2 x2
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd5, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [6:0] op);
        return {imm, 5'd1, f3, 5'd5, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [6:0] op);
        return {imm, 5'd5, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd5, 7'h6f};
    endfunction

    task automatic add_row(input string name, input logic [31:0] word,
                           input logic [31:0] pc_v, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] rdv,
                           input logic [31:0] npc, input logic [31:0] maddr,
                           input logic [3:0] flags);
        rows.push_back('{name, word, pc_v, a, b, rdv, npc, maddr, flags});
    endtask

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] p;
        logic [31:0] q;
        logic [31:0] m1;
        p  = 32'hf0f0_00ff;
        q  = 32'h0ff0_0f0f;
        m1 = 32'hffff_ffff;
        add_row("add", enc_r(7'h00, 3'd0), 'h100, 5, 7, 12, 'h104, 0, 4'b1000);
        add_row("sub", enc_r(7'h20, 3'd0), 'h100, 5, 7, 'hffff_fffe, 'h104, 0, 4'b1000);
        add_row("and", enc_r(7'h00, 3'd7), 'h100, p, q, 'h00f0_000f, 'h104, 0, 4'b1000);
        add_row("or", enc_r(7'h00, 3'd6), 'h100, p, q, 'hfff0_0fff, 'h104, 0, 4'b1000);
        add_row("xor", enc_r(7'h00, 3'd4), 'h100, p, q, 'hff00_0ff0, 'h104, 0, 4'b1000);
        add_row("sll", enc_r(7'h00, 3'd1), 'h100, 3, 'h24, 'h30, 'h104, 0, 4'b1000);
        add_row("srl", enc_r(7'h00, 3'd5), 'h100, 'h8000_0010, 4, 'h0800_0001, 'h104, 0,
                4'b1000);
        add_row("sra", enc_r(7'h20, 3'd5), 'h100, 'h8000_0010, 4, 'hf800_0001, 'h104, 0,
                4'b1000);
        add_row("slt", enc_r(7'h00, 3'd2), 'h100, m1, 1, 1, 'h104, 0, 4'b1000);
        add_row("sltu", enc_r(7'h00, 3'd3), 'h100, m1, 1, 0, 'h104, 0, 4'b1000);
        // immediate forms
        add_row("addi", enc_i(12'hffd, 3'd0, 7'h13), 'h100, 10, 0, 7, 'h104, 0, 4'b1000);
        add_row("slli", enc_i(12'h01f, 3'd1, 7'h13), 'h100, 1, 0, 'h8000_0000, 'h104, 0,
                4'b1000);
        add_row("srli", enc_i(12'h01f, 3'd5, 7'h13), 'h100, 'h8000_0000, 0, 1, 'h104, 0,
                4'b1000);
        add_row("srai", enc_i(12'h41f, 3'd5, 7'h13), 'h100, 'h8000_0000, 0, m1, 'h104, 0,
                4'b1000);
        add_row("slti", enc_i(12'hfff, 3'd2, 7'h13), 'h100, 5, 0, 0, 'h104, 0, 4'b1000);
        add_row("sltiu", enc_i(12'hfff, 3'd3, 7'h13), 'h100, 5, 0, 1, 'h104, 0, 4'b1000);
        add_row("andi", enc_i(12'h0f0, 3'd7, 7'h13), 'h100, p, 0, 'hf0, 'h104, 0, 4'b1000);
        add_row("ori", enc_i(12'h800, 3'd6, 7'h13), 'h100, 0, 0, 'hffff_f800, 'h104, 0,
                4'b1000);
        add_row("xori", enc_i(12'hfff, 3'd4, 7'h13), 'h100, p, 0, 'h0f0f_ff00, 'h104, 0,
                4'b1000);
        add_row("lui", enc_u(20'h12345, 7'h37), 'h100, 0, 0, 'h1234_5000, 'h104, 0, 4'b1000);
        busy_poke_row = rows.size();
        add_row("auipc", enc_u(20'h00001, 7'h17), 'h100, 0, 0, 'h1100, 'h104, 0, 4'b1000);
        add_row("jal", enc_j(21'h1f_fff0), 'h200, 0, 0, 'h204, 'h1f0, 0, 4'b1000);
        add_row("jalr", enc_i(12'h005, 3'd0, 7'h67), 'h100, 'h1000, 0, 'h104, 'h1004, 0,
                4'b1000);
        // branches with target 0x140 unless noted
        add_row("beq_taken", enc_b(13'h1ff0, 3'd0), 'h100, 9, 9, 0, 'hf0, 0, 4'b0000);
        add_row("beq_not", enc_b(13'h0040, 3'd0), 'h100, 9, 8, 0, 'h104, 0, 4'b0000);
        add_row("bne_taken", enc_b(13'h0040, 3'd1), 'h100, 9, 8, 0, 'h140, 0, 4'b0000);
        add_row("bne_not", enc_b(13'h0040, 3'd1), 'h100, 9, 9, 0, 'h104, 0, 4'b0000);
        add_row("blt_taken", enc_b(13'h0040, 3'd4), 'h100, m1, 1, 0, 'h140, 0, 4'b0000);
        add_row("blt_not", enc_b(13'h0040, 3'd4), 'h100, 1, m1, 0, 'h104, 0, 4'b0000);
        add_row("bge_taken", enc_b(13'h0040, 3'd5), 'h100, 1, m1, 0, 'h140, 0, 4'b0000);
        add_row("bge_not", enc_b(13'h0040, 3'd5), 'h100, m1, 1, 0, 'h104, 0, 4'b0000);
        add_row("bltu_taken", enc_b(13'h0040, 3'd6), 'h100, 1, m1, 0, 'h140, 0, 4'b0000);
        add_row("bltu_not", enc_b(13'h0040, 3'd6), 'h100, m1, 1, 0, 'h104, 0, 4'b0000);
        add_row("bgeu_taken", enc_b(13'h0040, 3'd7), 'h100, m1, 1, 0, 'h140, 0, 4'b0000);
        add_row("bgeu_not", enc_b(13'h0040, 3'd7), 'h100, 1, m1, 0, 'h104, 0, 4'b0000);
        add_row("lw", enc_i(12'h010, 3'd2, 7'h03), 'h100, 'h2000, 0, 0, 'h104, 'h2010,
                4'b0100);
        add_row("lb", enc_i(12'hffc, 3'd0, 7'h03), 'h100, 'h2000, 0, 0, 'h104, 'h1ffc,
                4'b0100);
        add_row("sw", enc_s(12'h024, 3'd2), 'h100, 'h3000, 'h55, 0, 'h104, 'h3024, 4'b0010);
        add_row("sb", enc_s(12'hffc, 3'd0), 'h100, 'h3000, 'h55, 0, 'h104, 'h2ffc, 4'b0010);
        add_row("fence", enc_i(12'h000, 3'd0, 7'h0f), 'h100, 0, 0, 0, 'h104, 0, 4'b0000);
        add_row("bad_opcode", enc_i(12'h000, 3'd0, 7'h7f), 'h100, 0, 0, 0, 'h104, 0, 4'b0001);
        add_row("bad_funct7", enc_r(7'h01, 3'd0), 'h100, 5, 7, 0, 'h104, 0, 4'b0001);
        // jump target and load strobe must both be suppressed
        add_row("bad_jalr", enc_i(12'h005, 3'd1, 7'h67), 'h100, 'h1000, 0, 0, 'h104, 0,
                4'b0001);
        add_row("bad_load", enc_i(12'h010, 3'd3, 7'h03), 'h100, 'h2000, 0, 0, 'h104, 0,
                4'b0001);
        for (int k = 0; k < 2; k++) begin
            a = $random(seed);
            b = $random(seed);
            add_row("rand_add", enc_r(7'h00, 3'd0), 'h100, a, b, a + b, 'h104, 0, 4'b1000);
            add_row("rand_sub", enc_r(7'h20, 3'd0), 'h100, a, b, a - b, 'h104, 0, 4'b1000);
            add_row("rand_xor", enc_r(7'h00, 3'd4), 'h100, a, b, a ^ b, 'h104, 0, 4'b1000);
            add_row("rand_sltu", enc_r(7'h00, 3'd3), 'h100, a, b, (a < b) ? 32'd1 : 32'd0,
                    'h104, 0, 4'b1000);
        end
    endtask

    task automatic check_field(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] got);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("** Error: %s %s expected 0x%08h actual 0x%08h", test, field, exp, got);
        end
    endtask

    task automatic apply_row(input int i);
        int edges;
        @(posedge clk);
        start    <= 1'b1;
        instr    <= rows[i].word;
        pc       <= rows[i].pc;
        rs1_data <= rows[i].rs1;
        rs2_data <= rows[i].rs2;
        @(posedge clk);
        start <= 1'b0;
        edges = 0;
        @(negedge clk);
        while (!done) begin
            @(posedge clk);
            edges++;
            if (i == busy_poke_row && edges == 1) begin
                start    <= 1'b1; // dropped while the slice is busy
                instr    <= enc_r(7'h20, 3'd0);
                pc       <= 32'h4000;
                rs1_data <= 32'h1234;
                rs2_data <= 32'h5678;
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
        end
        check_field(rows[i].name, "latency", 32'd3, edges);
        check_field(rows[i].name, "busy", 32'd1, 32'(busy));
        check_field(rows[i].name, "rd_we", 32'(rows[i].flags[3]), 32'(rd_we));
        check_field(rows[i].name, "mem_read", 32'(rows[i].flags[2]), 32'(mem_read));
        check_field(rows[i].name, "mem_write", 32'(rows[i].flags[1]), 32'(mem_write));
        check_field(rows[i].name, "illegal", 32'(rows[i].flags[0]), 32'(illegal));
        check_field(rows[i].name, "next_pc", rows[i].next_pc, next_pc);
        if (rows[i].flags[3]) begin
            check_field(rows[i].name, "rd_data", rows[i].rd_data, rd_data);
            check_field(rows[i].name, "rd_addr", 32'd5, 32'(rd_addr));
        end
        if (rows[i].flags[2] || rows[i].flags[1]) begin
            check_field(rows[i].name, "mem_addr", rows[i].mem_addr, mem_addr);
        end
    endtask

    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, done did not arrive", cycle_count);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        seed     = 6;
        arst_n   = 1'b0;
        start    = 1'b0;
        instr    = '0;
        pc       = '0;
        rs1_data = '0;
        rs2_data = '0;
        build_table();
        cycle_limit = rows.size() * 6 + 50;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        foreach (rows[i]) begin
            apply_row(i);
        end
        @(posedge clk);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
common/rv_exec_pkg.sv
alu/alu.sv
alu/alu_controller.sv
hdl/phase_sequencer.sv
hdl/instr_decoder.sv
hdl/result_unit.sv
hdl/rv_exec_top.sv
verif/rv_exec_top_asserts.sv
verif/tb_rv_exec_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_exec_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^ALL CHECKS PASSED$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
